//--- ftq_frontend.f
+incdir+source
source/frontend_types_pkg.sv
source/backend_types_pkg.sv
source/ftb_predictor.sv
source/ftq.sv
source/ftb_update_gen.sv
source/ftq_frontend.sv
testbench/ftq_frontend_assertions.sv
testbench/ftq_frontend_tb.sv

//--- source/backend_types_pkg.sv
package backend_types_pkg;

    // redirect target plus the slot of the block that squashed
    typedef struct packed {
        frontend_types_pkg::addr_t redirect_pc;
        frontend_types_pkg::ftq_idx_t ftq_idx;
    } squash_info_t;

    // resolved branch of one fetch block
    typedef struct packed {
        frontend_types_pkg::ftq_idx_t ftq_idx;
        logic mispred;
        logic taken;
        frontend_types_pkg::block_offset_t fallthru;
        frontend_types_pkg::addr_t target;
        frontend_types_pkg::branch_type_e br_type;
    } branch_wb_t;

endpackage

//--- source/frontend_types_pkg.sv
`include "ftq_consts.svh"

package frontend_types_pkg;

    typedef logic [`FTQ_XLEN-1:0] addr_t;
    typedef logic [`FTQ_IDX_W-1:0] ftq_idx_t;
    typedef logic [`FTQ_OFFSET_W-1:0] block_offset_t;
    typedef logic [1:0] ftb_ctr_t;

    typedef enum logic [1:0] {
        BR_NONE,
        BR_COND,
        BR_JAL,
        BR_JALR
    } branch_type_e;

    // end_addr is exclusive
    typedef struct packed {
        addr_t start_addr;
        addr_t end_addr;
        logic taken;
        addr_t target;
        logic hit;
        ftb_ctr_t ctr;
    } pred_info_t;

    typedef struct packed {
        addr_t start_addr;
        block_offset_t size;
    } fetch_req_t;

    typedef struct packed {
        addr_t start_addr;
        block_offset_t fallthru;
        addr_t target;
        branch_type_e br_type;
        ftb_ctr_t ctr;
        logic entry_vld;
    } ftb_update_t;

endpackage

//--- source/ftb_predictor.sv
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftb_predictor (
    input  logic clk,
    input  logic rst,
    input  logic i_squash_vld,
    input  frontend_types_pkg::addr_t i_squash_pc,
    output logic o_pred_vld,
    output frontend_types_pkg::pred_info_t o_pred_info,
    input  logic i_ftq_rdy,
    input  logic i_update_vld,
    input  frontend_types_pkg::ftb_update_t i_update_info,
    output logic o_update_done
);
    import frontend_types_pkg::*;

    localparam int BLK_SHIFT = $clog2(`FTQ_BLOCK_BYTES);
    localparam int TAG_HI_LSB = BLK_SHIFT + `FTB_IDX_W;

    typedef logic [`FTB_IDX_W-1:0] ftb_idx_t;
    typedef logic [`FTB_TAG_W-1:0] ftb_tag_t;

    typedef struct packed {
        ftb_tag_t tag;
        block_offset_t fallthru;
        addr_t target;
        branch_type_e br_type;
        ftb_ctr_t ctr;
    } ftb_entry_t;

    addr_t pc;
    addr_t next_pc;
    logic run;
    logic done_q;
    logic [`FTB_SETS-1:0] ftb_vld;
    ftb_entry_t ftb_mem [`FTB_SETS];
    ftb_entry_t rd_entry;
    ftb_idx_t rd_idx;
    ftb_idx_t wr_idx;
    logic hit;
    logic is_jump;

    // index skips the block offset bits
    function automatic ftb_idx_t ftb_index(input addr_t addr);
        return addr[BLK_SHIFT +: `FTB_IDX_W];
    endfunction

    function automatic ftb_tag_t ftb_tag(input addr_t addr);
        return {addr[`FTQ_XLEN-1:TAG_HI_LSB], addr[BLK_SHIFT-1:0]};
    endfunction

    assign rd_idx = ftb_index(pc);
    assign rd_entry = ftb_mem[rd_idx];
    assign hit = ftb_vld[rd_idx] && (rd_entry.tag == ftb_tag(pc));
    assign is_jump = (rd_entry.br_type == BR_JAL) || (rd_entry.br_type == BR_JALR);

    always_comb begin
        o_pred_info.start_addr = pc;
        o_pred_info.hit = hit;
        if (hit) begin
            o_pred_info.end_addr = pc + addr_t'(rd_entry.fallthru);
            o_pred_info.taken = rd_entry.ctr[1] || is_jump;
            o_pred_info.target = rd_entry.target;
            o_pred_info.ctr = rd_entry.ctr;
        end else begin
            // miss falls through a full block
            o_pred_info.end_addr = pc + addr_t'(`FTQ_BLOCK_BYTES);
            o_pred_info.taken = 1'b0;
            o_pred_info.target = pc + addr_t'(`FTQ_BLOCK_BYTES);
            o_pred_info.ctr = 2'b01;
        end
    end

    assign next_pc = o_pred_info.taken ? o_pred_info.target : o_pred_info.end_addr;
    assign o_pred_vld = run && !i_squash_vld;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= `FTQ_RESET_PC;
            run <= 1'b0;
        end else begin
            run <= 1'b1;
            if (i_squash_vld) begin
                pc <= i_squash_pc;
            end else if (o_pred_vld && i_ftq_rdy) begin
                pc <= next_pc;
            end
        end
    end

    // training writes
    assign wr_idx = ftb_index(i_update_info.start_addr);

    always_ff @(posedge clk) begin
        if (rst) begin
            ftb_vld <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= i_update_vld;
            if (i_update_vld) begin
                ftb_vld[wr_idx] <= i_update_info.entry_vld;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_update_vld) begin
            ftb_mem[wr_idx] <= '{
                tag      : ftb_tag(i_update_info.start_addr),
                fallthru : i_update_info.fallthru,
                target   : i_update_info.target,
                br_type  : i_update_info.br_type,
                ctr      : i_update_info.ctr
            };
        end
    end

    assign o_update_done = done_q;

endmodule

//--- source/ftb_update_gen.sv
`timescale 1ns/1ps

module ftb_update_gen (
    input  logic clk,
    input  logic rst,
    input  logic i_retire_vld,
    input  logic i_retire_train,
    input  frontend_types_pkg::pred_info_t i_retire_pred,
    input  backend_types_pkg::branch_wb_t i_retire_wb,
    output logic o_update_vld,
    output frontend_types_pkg::ftb_update_t o_update_info
);
    import frontend_types_pkg::*;

    ftb_ctr_t old_ctr;
    ftb_ctr_t new_ctr;

    assign old_ctr = i_retire_pred.ctr;

    always_comb begin
        if (!i_retire_pred.hit) begin
            // fresh entry starts weak in the resolved direction
            new_ctr = i_retire_wb.taken ? 2'b10 : 2'b01;
        end else if (i_retire_wb.taken) begin
            new_ctr = (old_ctr == 2'b11) ? 2'b11 : old_ctr + 2'b01;
        end else begin
            new_ctr = (old_ctr == 2'b00) ? 2'b00 : old_ctr - 2'b01;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            o_update_vld <= 1'b0;
        end else begin
            o_update_vld <= i_retire_vld && i_retire_train;
        end
    end

    // no resolved branch in the block drops the entry
    always_ff @(posedge clk) begin
        if (i_retire_vld) begin
            o_update_info <= '{
                start_addr : i_retire_pred.start_addr,
                fallthru   : i_retire_wb.fallthru,
                target     : i_retire_wb.target,
                br_type    : i_retire_wb.br_type,
                ctr        : new_ctr,
                entry_vld  : (i_retire_wb.br_type != BR_NONE)
            };
        end
    end

endmodule

//--- source/ftq.sv
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq (
    input  logic clk,
    input  logic rst,
    input  logic i_pred_vld,
    input  frontend_types_pkg::pred_info_t i_pred_info,
    output logic o_ftq_rdy,
    output logic o_fetch_req,
    output frontend_types_pkg::ftq_idx_t o_fetch_idx,
    output frontend_types_pkg::fetch_req_t o_fetch_info,
    input  logic i_fetch_rdy,
    input  frontend_types_pkg::ftq_idx_t i_read_idx [`FTQ_BRU_NUM],
    output frontend_types_pkg::addr_t o_read_start [`FTQ_BRU_NUM],
    output frontend_types_pkg::addr_t o_read_next [`FTQ_BRU_NUM],
    input  logic i_wb_vld [`FTQ_BRU_NUM],
    input  backend_types_pkg::branch_wb_t i_wb_info [`FTQ_BRU_NUM],
    input  logic i_commit_vld,
    input  frontend_types_pkg::ftq_idx_t i_commit_idx,
    input  logic i_squash_vld,
    input  frontend_types_pkg::ftq_idx_t i_squash_idx,
    output logic o_retire_vld,
    output frontend_types_pkg::pred_info_t o_retire_pred,
    output backend_types_pkg::branch_wb_t o_retire_wb,
    output logic o_retire_train,
    input  logic i_update_done
);
    import frontend_types_pkg::*;
    import backend_types_pkg::*;

    typedef logic [`FTQ_IDX_W:0] ftq_cnt_t;

    ftq_idx_t pred_ptr;
    ftq_idx_t fetch_ptr;
    ftq_idx_t commit_ptr;
    ftq_idx_t commit_thre;
    ftq_idx_t commit_next;
    ftq_idx_t squash_next;
    ftq_cnt_t count;
    ftq_cnt_t unfetched;
    ftq_cnt_t squash_count;
    logic train_wait;
    logic push;
    logic do_fetch;
    logic fetch_fire;
    logic do_commit;
    logic need_train;
    logic pop;

    pred_info_t pred_mem [`FTQ_SIZE];
    addr_t next_mem [`FTQ_SIZE];
    branch_wb_t wb_mem [`FTQ_SIZE];
    logic [`FTQ_SIZE-1:0] slot_mispred;
    pred_info_t fetch_entry;

    function automatic ftq_idx_t ptr_inc(input ftq_idx_t p);
        return (p == ftq_idx_t'(`FTQ_SIZE - 1)) ? '0 : p + 1'b1;
    endfunction

    assign o_ftq_rdy = (count != ftq_cnt_t'(`FTQ_SIZE));
    assign push = i_pred_vld && o_ftq_rdy && !i_squash_vld;
    assign do_fetch = (unfetched != '0);
    assign fetch_fire = do_fetch && i_fetch_rdy;
    assign do_commit = (commit_ptr != commit_thre);
    assign need_train = pred_mem[commit_ptr].hit || slot_mispred[commit_ptr];
    // training entries leave only once the predictor is done
    assign pop = do_commit && (!need_train || i_update_done);
    assign commit_next = pop ? ptr_inc(commit_ptr) : commit_ptr;
    assign squash_next = ptr_inc(i_squash_idx);

    // survivors run from commit_next up to the squashing block
    always_comb begin
        if (i_squash_idx >= commit_next) begin
            squash_count = ftq_cnt_t'(i_squash_idx - commit_next) + 1'b1;
        end else begin
            squash_count = ftq_cnt_t'(i_squash_idx) + ftq_cnt_t'(`FTQ_SIZE)
                           - ftq_cnt_t'(commit_next) + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pred_ptr <= '0;
            fetch_ptr <= '0;
            commit_ptr <= '0;
            commit_thre <= '0;
            count <= '0;
            unfetched <= '0;
            train_wait <= 1'b0;
        end else begin
            if (i_squash_vld) begin
                pred_ptr <= squash_next;
                fetch_ptr <= squash_next;
                count <= squash_count;
                unfetched <= '0;
            end else begin
                if (push) begin
                    pred_ptr <= ptr_inc(pred_ptr);
                end
                if (fetch_fire) begin
                    fetch_ptr <= ptr_inc(fetch_ptr);
                end
                count <= count + ftq_cnt_t'(push) - ftq_cnt_t'(pop);
                unfetched <= unfetched + ftq_cnt_t'(push) - ftq_cnt_t'(fetch_fire);
            end
            // a mispredicted block retires with its commit
            if (i_commit_vld) begin
                commit_thre <= slot_mispred[i_commit_idx] ? ptr_inc(i_commit_idx) : i_commit_idx;
            end
            if (pop) begin
                commit_ptr <= ptr_inc(commit_ptr);
                train_wait <= 1'b0;
            end else if (o_retire_vld && need_train) begin
                train_wait <= 1'b1;
            end
        end
    end

    // entry storage and backend reads
    always_ff @(posedge clk) begin
        if (push) begin
            pred_mem[pred_ptr] <= i_pred_info;
            next_mem[pred_ptr] <= i_pred_info.taken ? i_pred_info.target : i_pred_info.end_addr;
            wb_mem[pred_ptr] <= '{
                ftq_idx  : pred_ptr,
                mispred  : 1'b0,
                taken    : i_pred_info.taken,
                fallthru : block_offset_t'(i_pred_info.end_addr - i_pred_info.start_addr),
                target   : i_pred_info.target,
                br_type  : BR_NONE
            };
        end
        for (int b = 0; b < `FTQ_BRU_NUM; b++) begin
            if (i_wb_vld[b]) begin
                wb_mem[i_wb_info[b].ftq_idx] <= i_wb_info[b];
            end
            o_read_start[b] <= pred_mem[i_read_idx[b]].start_addr;
            o_read_next[b] <= next_mem[i_read_idx[b]];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_mispred <= '0;
        end else begin
            if (push) begin
                slot_mispred[pred_ptr] <= 1'b0;
            end
            for (int b = 0; b < `FTQ_BRU_NUM; b++) begin
                if (i_wb_vld[b]) begin
                    slot_mispred[i_wb_info[b].ftq_idx] <= i_wb_info[b].mispred;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int a = 0; a < `FTQ_BRU_NUM; a++) begin
                for (int b = a + 1; b < `FTQ_BRU_NUM; b++) begin
                    if (i_wb_vld[a] && i_wb_vld[b]) begin
                        assert (i_wb_info[a].ftq_idx != i_wb_info[b].ftq_idx)
                            else $error("ftq: two writebacks to slot %0d", i_wb_info[a].ftq_idx);
                    end
                end
            end
        end
    end

    // cache request
    assign fetch_entry = pred_mem[fetch_ptr];
    assign o_fetch_req = do_fetch;
    assign o_fetch_idx = fetch_ptr;
    assign o_fetch_info = '{
        start_addr : fetch_entry.start_addr,
        size       : block_offset_t'(fetch_entry.end_addr - fetch_entry.start_addr)
    };

    // retirement towards the update generator
    assign o_retire_vld = do_commit && !train_wait;
    assign o_retire_train = need_train;
    assign o_retire_pred = pred_mem[commit_ptr];

    always_comb begin
        o_retire_wb = wb_mem[commit_ptr];
        o_retire_wb.mispred = slot_mispred[commit_ptr];
    end

endmodule

//--- source/ftq_consts.svh
`ifndef FTQ_CONSTS_SVH
`define FTQ_CONSTS_SVH

// address and queue geometry
`define FTQ_XLEN 32
`define FTQ_SIZE 8
`define FTQ_IDX_W 3
`define FTQ_BRU_NUM 2

// offset width holds a full fetch block length
`define FTQ_BLOCK_BYTES 32
`define FTQ_OFFSET_W 6
`define FTQ_RESET_PC 32'h8000_0000

// direct-mapped ftb tag keeps every pc bit outside the index
`define FTB_SETS 16
`define FTB_IDX_W 4
`define FTB_TAG_W (`FTQ_XLEN - `FTB_IDX_W)

`endif

//--- source/ftq_frontend.sv
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_frontend (
    input  logic clk,
    input  logic rst,
    output logic o_fetch_req,
    output frontend_types_pkg::ftq_idx_t o_fetch_idx,
    output frontend_types_pkg::fetch_req_t o_fetch_info,
    input  logic i_fetch_rdy,
    input  frontend_types_pkg::ftq_idx_t i_read_idx [`FTQ_BRU_NUM],
    output frontend_types_pkg::addr_t o_read_start [`FTQ_BRU_NUM],
    output frontend_types_pkg::addr_t o_read_next [`FTQ_BRU_NUM],
    input  logic i_wb_vld [`FTQ_BRU_NUM],
    input  backend_types_pkg::branch_wb_t i_wb_info [`FTQ_BRU_NUM],
    input  logic i_commit_vld,
    input  frontend_types_pkg::ftq_idx_t i_commit_idx,
    input  logic i_squash_vld,
    input  backend_types_pkg::squash_info_t i_squash_info
);
    import frontend_types_pkg::*;
    import backend_types_pkg::*;

    logic pred_vld;
    logic ftq_rdy;
    pred_info_t pred_info;
    logic retire_vld;
    logic retire_train;
    pred_info_t retire_pred;
    branch_wb_t retire_wb;
    logic update_vld;
    logic update_done;
    ftb_update_t update_info;

    ftb_predictor u_predictor (
        .clk           (clk),
        .rst           (rst),
        .i_squash_vld  (i_squash_vld),
        .i_squash_pc   (i_squash_info.redirect_pc),
        .o_pred_vld    (pred_vld),
        .o_pred_info   (pred_info),
        .i_ftq_rdy     (ftq_rdy),
        .i_update_vld  (update_vld),
        .i_update_info (update_info),
        .o_update_done (update_done)
    );

    ftq u_ftq (
        .clk            (clk),
        .rst            (rst),
        .i_pred_vld     (pred_vld),
        .i_pred_info    (pred_info),
        .o_ftq_rdy      (ftq_rdy),
        .o_fetch_req    (o_fetch_req),
        .o_fetch_idx    (o_fetch_idx),
        .o_fetch_info   (o_fetch_info),
        .i_fetch_rdy    (i_fetch_rdy),
        .i_read_idx     (i_read_idx),
        .o_read_start   (o_read_start),
        .o_read_next    (o_read_next),
        .i_wb_vld       (i_wb_vld),
        .i_wb_info      (i_wb_info),
        .i_commit_vld   (i_commit_vld),
        .i_commit_idx   (i_commit_idx),
        .i_squash_vld   (i_squash_vld),
        .i_squash_idx   (i_squash_info.ftq_idx),
        .o_retire_vld   (retire_vld),
        .o_retire_pred  (retire_pred),
        .o_retire_wb    (retire_wb),
        .o_retire_train (retire_train),
        .i_update_done  (update_done)
    );

    ftb_update_gen u_update_gen (
        .clk            (clk),
        .rst            (rst),
        .i_retire_vld   (retire_vld),
        .i_retire_train (retire_train),
        .i_retire_pred  (retire_pred),
        .i_retire_wb    (retire_wb),
        .o_update_vld   (update_vld),
        .o_update_info  (update_info)
    );

endmodule

//--- testbench/ftq_frontend_assertions.sv
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_frontend_assertions (
    input logic clk,
    input logic rst,
    input logic o_fetch_req,
    input frontend_types_pkg::ftq_idx_t o_fetch_idx,
    input frontend_types_pkg::fetch_req_t o_fetch_info,
    input logic i_fetch_rdy,
    input frontend_types_pkg::ftq_idx_t i_read_idx [`FTQ_BRU_NUM],
    input frontend_types_pkg::addr_t o_read_start [`FTQ_BRU_NUM],
    input frontend_types_pkg::addr_t o_read_next [`FTQ_BRU_NUM],
    input logic i_wb_vld [`FTQ_BRU_NUM],
    input backend_types_pkg::branch_wb_t i_wb_info [`FTQ_BRU_NUM],
    input logic i_commit_vld,
    input frontend_types_pkg::ftq_idx_t i_commit_idx,
    input logic i_squash_vld,
    input backend_types_pkg::squash_info_t i_squash_info
);
    import frontend_types_pkg::*;
    import backend_types_pkg::*;

    // details of the first failing check
    int err_cnt;
    string err_name;
    string err_msg;
    logic err_is_value;
    logic [`FTQ_XLEN-1:0] err_exp;
    logic [`FTQ_XLEN-1:0] err_act;

    logic fire;
    addr_t exp_addr;
    ftq_idx_t exp_idx;
    block_offset_t exp_size;
    addr_t exp_next;
    logic train_hit;
    logic clean;
    logic [`FTQ_IDX_W:0] fill_cnt;
    addr_t fetch_addr [`FTQ_SIZE];
    logic [`FTQ_SIZE-1:0] live;
    logic [`FTQ_SIZE-1:0] wb_flag;
    block_offset_t wb_off [`FTQ_SIZE];
    addr_t wb_tgt [`FTQ_SIZE];
    logic train_vld;
    addr_t train_addr;
    block_offset_t train_off;
    addr_t train_tgt;
    logic rd_live_q [`FTQ_BRU_NUM];
    addr_t rd_start_q [`FTQ_BRU_NUM];

    task automatic record_failure(input string name, input string msg, input logic is_value,
                                  input logic [`FTQ_XLEN-1:0] exp, input logic [`FTQ_XLEN-1:0] act);
        if (err_cnt == 0) begin
            err_name = name;
            err_msg = msg;
            err_is_value = is_value;
            err_exp = exp;
            err_act = act;
        end
        err_cnt++;
    endtask

    function automatic ftq_idx_t idx_inc(input ftq_idx_t p);
        return (p == ftq_idx_t'(`FTQ_SIZE - 1)) ? '0 : p + 1'b1;
    endfunction

    initial err_cnt = 0;

    assign fire = o_fetch_req && i_fetch_rdy;
    // a committed mispredicted jump trains one block
    assign train_hit = train_vld && (exp_addr == train_addr);
    assign exp_size = train_hit ? train_off : block_offset_t'(`FTQ_BLOCK_BYTES);
    assign exp_next = train_hit ? train_tgt : exp_addr + addr_t'(`FTQ_BLOCK_BYTES);

    always_ff @(posedge clk) begin
        if (rst) begin
            exp_addr <= `FTQ_RESET_PC;
            exp_idx <= '0;
            live <= '0;
            wb_flag <= '0;
            train_vld <= 1'b0;
            clean <= 1'b1;
            fill_cnt <= '0;
        end else begin
            if (fire) begin
                fetch_addr[exp_idx] <= exp_addr;
                live[exp_idx] <= clean;
                fill_cnt <= fill_cnt + 1'b1;
            end
            if (i_squash_vld) begin
                exp_addr <= i_squash_info.redirect_pc;
                exp_idx <= idx_inc(i_squash_info.ftq_idx);
                live <= '0;
                clean <= 1'b0;
            end else if (fire) begin
                exp_addr <= exp_next;
                exp_idx <= idx_inc(exp_idx);
            end
            for (int b = 0; b < `FTQ_BRU_NUM; b++) begin
                if (i_wb_vld[b]) begin
                    wb_flag[i_wb_info[b].ftq_idx] <= i_wb_info[b].mispred && i_wb_info[b].taken
                                                     && (i_wb_info[b].br_type != BR_NONE);
                    wb_off[i_wb_info[b].ftq_idx] <= i_wb_info[b].fallthru;
                    wb_tgt[i_wb_info[b].ftq_idx] <= i_wb_info[b].target;
                end
            end
            if (i_commit_vld) begin
                clean <= 1'b0;
                live <= '0;
                if (wb_flag[i_commit_idx]) begin
                    train_vld <= 1'b1;
                    train_addr <= fetch_addr[i_commit_idx];
                    train_off <= wb_off[i_commit_idx];
                    train_tgt <= wb_tgt[i_commit_idx];
                end
            end
        end
    end

    // read ports answer one cycle later
    always_ff @(posedge clk) begin
        for (int b = 0; b < `FTQ_BRU_NUM; b++) begin
            rd_live_q[b] <= !rst && live[i_read_idx[b]] && clean;
            rd_start_q[b] <= fetch_addr[i_read_idx[b]];
        end
    end

    fetch_addr_a: assert property (@(posedge clk) disable iff (rst)
        fire |-> o_fetch_info.start_addr == exp_addr)
        else begin
            record_failure("fetch_addr", "", 1'b1, $sampled(exp_addr),
                           $sampled(o_fetch_info.start_addr));
            $error("fetch address mismatch");
        end

    fetch_idx_a: assert property (@(posedge clk) disable iff (rst)
        fire |-> o_fetch_idx == exp_idx)
        else begin
            record_failure("fetch_idx", "", 1'b1, $sampled(exp_idx), $sampled(o_fetch_idx));
            $error("fetch index mismatch");
        end

    fetch_size_a: assert property (@(posedge clk) disable iff (rst)
        fire |-> o_fetch_info.size == exp_size)
        else begin
            record_failure("fetch_size", "", 1'b1, $sampled(exp_size),
                           $sampled(o_fetch_info.size));
            $error("fetch size mismatch");
        end

    fetch_hold_a: assert property (@(posedge clk) disable iff (rst)
        o_fetch_req && !i_fetch_rdy && !i_squash_vld |=>
            o_fetch_req && $stable(o_fetch_idx) && $stable(o_fetch_info))
        else begin
            record_failure("fetch_hold", "fetch request changed while the cache was not ready",
                           1'b0, '0, '0);
            $error("fetch request not held");
        end

    fill_limit_a: assert property (@(posedge clk) disable iff (rst)
        clean && fire |-> fill_cnt < `FTQ_SIZE)
        else begin
            record_failure("fill_limit", "more fetches than queue entries without a commit",
                           1'b0, '0, '0);
            $error("queue overfetch");
        end

    for (genvar b = 0; b < `FTQ_BRU_NUM; b++) begin : g_read
        read_start_a: assert property (@(posedge clk) disable iff (rst)
            rd_live_q[b] |-> o_read_start[b] == rd_start_q[b])
            else begin
                record_failure("read_start", "", 1'b1, $sampled(rd_start_q[b]),
                               $sampled(o_read_start[b]));
                $error("read start mismatch");
            end

        read_next_a: assert property (@(posedge clk) disable iff (rst)
            rd_live_q[b] |-> o_read_next[b] == rd_start_q[b] + addr_t'(`FTQ_BLOCK_BYTES))
            else begin
                record_failure("read_next", "", 1'b1,
                               $sampled(rd_start_q[b]) + addr_t'(`FTQ_BLOCK_BYTES),
                               $sampled(o_read_next[b]));
                $error("read next mismatch");
            end
    end

endmodule

bind ftq_frontend ftq_frontend_assertions u_chk (
    .clk           (clk),
    .rst           (rst),
    .o_fetch_req   (o_fetch_req),
    .o_fetch_idx   (o_fetch_idx),
    .o_fetch_info  (o_fetch_info),
    .i_fetch_rdy   (i_fetch_rdy),
    .i_read_idx    (i_read_idx),
    .o_read_start  (o_read_start),
    .o_read_next   (o_read_next),
    .i_wb_vld      (i_wb_vld),
    .i_wb_info     (i_wb_info),
    .i_commit_vld  (i_commit_vld),
    .i_commit_idx  (i_commit_idx),
    .i_squash_vld  (i_squash_vld),
    .i_squash_info (i_squash_info)
);

//--- testbench/ftq_frontend_tb.sv
`timescale 1ns/1ps
`include "ftq_consts.svh"

module ftq_frontend_tb;
    import frontend_types_pkg::*;
    import backend_types_pkg::*;

    localparam int CLK_PERIOD = 4;
    localparam int RESET_CYCLES = 10;
    // roughly three times the expected run length
    localparam int TEST_CYCLES = 400;
    localparam addr_t BLOCK_A = `FTQ_RESET_PC + 32'h40;
    localparam addr_t TARGET_T = `FTQ_RESET_PC + 32'h400;

    logic clk;
    logic rst;
    logic o_fetch_req;
    ftq_idx_t o_fetch_idx;
    fetch_req_t o_fetch_info;
    logic i_fetch_rdy;
    ftq_idx_t i_read_idx [`FTQ_BRU_NUM];
    addr_t o_read_start [`FTQ_BRU_NUM];
    addr_t o_read_next [`FTQ_BRU_NUM];
    logic i_wb_vld [`FTQ_BRU_NUM];
    branch_wb_t i_wb_info [`FTQ_BRU_NUM];
    logic i_commit_vld;
    ftq_idx_t i_commit_idx;
    logic i_squash_vld;
    squash_info_t i_squash_info;

    int seed;
    int fetch_count;

    ftq_frontend i_dut (
        .clk           (clk),
        .rst           (rst),
        .o_fetch_req   (o_fetch_req),
        .o_fetch_idx   (o_fetch_idx),
        .o_fetch_info  (o_fetch_info),
        .i_fetch_rdy   (i_fetch_rdy),
        .i_read_idx    (i_read_idx),
        .o_read_start  (o_read_start),
        .o_read_next   (o_read_next),
        .i_wb_vld      (i_wb_vld),
        .i_wb_info     (i_wb_info),
        .i_commit_vld  (i_commit_vld),
        .i_commit_idx  (i_commit_idx),
        .i_squash_vld  (i_squash_vld),
        .i_squash_info (i_squash_info)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // cache accepts about three requests in four
    always @(posedge clk) begin
        if (rst) begin
            i_fetch_rdy <= 1'b0;
        end else begin
            i_fetch_rdy <= (($random(seed) & 3) != 0);
        end
    end

    always @(posedge clk) begin
        if (!rst && o_fetch_req && i_fetch_rdy) begin
            fetch_count <= fetch_count + 1;
        end
    end

    task automatic wait_fetches(input int n);
        int target;
        target = fetch_count + n;
        while (fetch_count < target) begin
            @(posedge clk);
        end
    endtask

    task automatic read_pair(input ftq_idx_t idx0, input ftq_idx_t idx1);
        @(posedge clk);
        i_read_idx[0] <= idx0;
        i_read_idx[1] <= idx1;
    endtask

    task automatic send_writeback(input ftq_idx_t idx, input block_offset_t off,
                                  input addr_t tgt);
        @(posedge clk);
        i_wb_vld[0] <= 1'b1;
        i_wb_info[0] <= '{ftq_idx: idx, mispred: 1'b1, taken: 1'b1, fallthru: off,
                          target: tgt, br_type: BR_JAL};
        @(posedge clk);
        i_wb_vld[0] <= 1'b0;
    endtask

    task automatic send_commit(input ftq_idx_t idx);
        @(posedge clk);
        i_commit_vld <= 1'b1;
        i_commit_idx <= idx;
        @(posedge clk);
        i_commit_vld <= 1'b0;
    endtask

    task automatic send_squash(input ftq_idx_t idx, input addr_t pc);
        @(posedge clk);
        i_squash_vld <= 1'b1;
        i_squash_info <= '{redirect_pc: pc, ftq_idx: idx};
        @(posedge clk);
        i_squash_vld <= 1'b0;
    endtask

    // first assertion failure ends the run
    initial begin
        wait (i_dut.u_chk.err_cnt != 0);
        #1;
        if (i_dut.u_chk.err_is_value) begin
            $display("FAIL %s expected %0h actual %0h", i_dut.u_chk.err_name,
                     i_dut.u_chk.err_exp, i_dut.u_chk.err_act);
        end else begin
            $display("check %s failed: %s", i_dut.u_chk.err_name, i_dut.u_chk.err_msg);
        end
        $display("TEST FAILED");
        $fatal(1, "assertion failure");
    end

    initial begin
        #(TEST_CYCLES * CLK_PERIOD);
        $display("timeout: the run did not complete in time");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed = 32'h8c80f115;
        fetch_count = 0;
        clk = 1'b0;
        rst = 1'b1;
        i_fetch_rdy = 1'b0;
        i_commit_vld = 1'b0;
        i_commit_idx = '0;
        i_squash_vld = 1'b0;
        i_squash_info = '0;
        for (int b = 0; b < `FTQ_BRU_NUM; b++) begin
            i_read_idx[b] = '0;
            i_wb_vld[b] = 1'b0;
            i_wb_info[b] = '0;
        end
        repeat (RESET_CYCLES) @(posedge clk);
        rst <= 1'b0;

        // fill the queue with no commits, then hold
        wait_fetches(`FTQ_SIZE);
        repeat (12) @(posedge clk);
        for (int j = 0; j < `FTQ_SIZE; j++) begin
            read_pair(ftq_idx_t'(j), ftq_idx_t'(`FTQ_SIZE - 1 - j));
        end
        repeat (2) @(posedge clk);

        // slot 2 holds BLOCK_A and resolves as a taken jump
        send_writeback(3'd2, 6'd12, TARGET_T);
        send_commit(3'd2);
        // three freed slots refill once slot 2 has trained the ftb
        wait_fetches(3);
        send_squash(3'd3, BLOCK_A);
        wait_fetches(4);
        repeat (5) @(posedge clk);

        send_squash(3'd6, `FTQ_RESET_PC + 32'h1000);
        wait_fetches(3);
        repeat (5) @(posedge clk);
        @(negedge clk);

        if (i_dut.u_chk.err_cnt == 0) begin
            $display("TEST PASSED");
            $finish;
        end else begin
            $display("TEST FAILED");
            $fatal(1, "checks failed");
        end
    end

endmodule
